// ==== include/sched_settings.svh ====
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// command FIFO size, in raw 80-bit words
`define SCHED_FIFO_DEPTH 8

// channel registers in the bank
`define SCHED_NUM_CHAN 4

// bus address of channel 0
// later channels follow on consecutive addresses
`define SCHED_CHAN_BASE 16'h0040

`endif

// ==== src/sched_bus_pkg.sv ====
package sched_bus_pkg;

	`include "sched_settings.svh"

	// at least one bit, even for a single channel
	localparam int CHAN_W = (`SCHED_NUM_CHAN > 1) ? $clog2(`SCHED_NUM_CHAN) : 1;

	typedef logic [CHAN_W-1:0] chan_idx_t;

	// one write on the internal bus, strobe plus payload
	typedef struct packed {
		logic en;          // single-cycle write strobe
		chan_idx_t chan;   // target register
		logic [31:0] data;
	} bus_wr_t;

endpackage

// ==== src/sched_cmd_pkg.sv ====
package sched_cmd_pkg;

	import sched_bus_pkg::chan_idx_t;

	// word as pushed by the host
	// time in the top bits, then data, then bus address
	typedef struct packed {
		logic [31:0] cmd_time;
		logic [31:0] data;
		logic [15:0] addr;
	} raw_cmd_t;

	// command after the address check
	typedef struct packed {
		logic [31:0] cmd_time;
		chan_idx_t chan;
		logic [31:0] data;
	} sched_cmd_t;

endpackage

// ==== src/sched_timebase.sv ====
`timescale 1ns/10ps

module sched_timebase (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic stop,
	output logic running,
	output logic [31:0] current_time
);

	// stop wins over start if both arrive together
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			running <= 1'b0;
			current_time <= '0;
		end else if (stop) begin
			running <= 1'b0;
			current_time <= '0;
		end else begin
			if (start)
				running <= 1'b1;
			if (running)
				current_time <= current_time + 32'd1; // wraps after 2^32 ticks
		end
	end

endmodule

// ==== src/cmd_fifo.sv ====
`timescale 1ns/10ps

`include "sched_settings.svh"

module cmd_fifo (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	output logic in_ready,
	input  sched_cmd_pkg::raw_cmd_t in_data,
	output logic out_valid,
	input  logic out_ready,
	output sched_cmd_pkg::raw_cmd_t out_data
);

	import sched_cmd_pkg::*;

	localparam int DEPTH = `SCHED_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	raw_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// wrap explicitly so a non power of two depth also works
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign out_valid = (count != '0);
	// full, but a pop this cycle frees a slot
	assign in_ready = (count != CNT_W'(DEPTH)) || out_ready;
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	assign out_data = mem[rd_ptr]; // head entry, straight from storage

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none, or push and pop together
			endcase
		end
	end

endmodule

// ==== src/sched_decode.sv ====
`timescale 1ns/10ps

`include "sched_settings.svh"

module sched_decode (
	input  logic clk,
	input  logic rst,
	input  logic raw_valid,
	output logic raw_ready,
	input  sched_cmd_pkg::raw_cmd_t raw,
	output logic cmd_valid,
	input  logic cmd_ready,
	output sched_cmd_pkg::sched_cmd_t cmd,
	output logic [15:0] bad_cmd_count
);

	import sched_bus_pkg::*;

	logic [15:0] offset;
	logic addr_ok;
	logic pop;
	chan_idx_t chan;

	// distance from channel 0, only meaningful when addr >= base
	assign offset = raw.addr - `SCHED_CHAN_BASE;
	assign addr_ok = (raw.addr >= `SCHED_CHAN_BASE) &&
		(offset < 16'(`SCHED_NUM_CHAN));
	assign chan = offset[CHAN_W-1:0];

	// slot empty, or its command leaves this cycle
	assign raw_ready = !cmd_valid || cmd_ready;
	assign pop = raw_valid && raw_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cmd_valid <= 1'b0;
			bad_cmd_count <= '0;
		end else begin
			if (pop) begin
				cmd_valid <= addr_ok; // a bad word leaves the slot empty
				if (!addr_ok && bad_cmd_count != 16'hffff)
					bad_cmd_count <= bad_cmd_count + 16'd1;
			end else if (cmd_ready) begin
				cmd_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop && addr_ok) begin
			cmd.cmd_time <= raw.cmd_time;
			cmd.chan <= chan;
			cmd.data <= raw.data;
		end
	end

endmodule

// ==== src/sched_execute.sv ====
`timescale 1ns/10ps

module sched_execute (
	input  logic clk,
	input  logic rst,
	input  logic running,
	input  logic [31:0] current_time,
	input  logic cmd_valid,
	output logic cmd_ready,
	input  sched_cmd_pkg::sched_cmd_t cmd,
	output sched_bus_pkg::bus_wr_t bus_wr
);

	import sched_cmd_pkg::*;

	sched_cmd_t held;
	logic held_valid;
	logic due;

	assign cmd_ready = !held_valid;

	// nothing fires until the timebase has been started
	assign due = held_valid && running && (current_time >= held.cmd_time);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			held_valid <= 1'b0;
			bus_wr <= '0;
		end else begin
			bus_wr.en <= due; // one cycle, slot frees at the same edge
			if (due) begin
				bus_wr.chan <= held.chan;
				bus_wr.data <= held.data;
			end
			if (cmd_valid && cmd_ready)
				held_valid <= 1'b1;
			else if (due)
				held_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready)
			held <= cmd;
	end

endmodule

// ==== src/channel_bank.sv ====
`timescale 1ns/10ps

`include "sched_settings.svh"

module channel_bank (
	input  logic clk,
	input  logic rst,
	input  sched_bus_pkg::bus_wr_t bus_wr,
	output logic [`SCHED_NUM_CHAN-1:0][31:0] chan_value,
	output logic [`SCHED_NUM_CHAN-1:0] chan_update
);

	import sched_bus_pkg::*;

	logic [`SCHED_NUM_CHAN-1:0] hit;

	// one-hot select of the written channel
	always_comb begin
		for (int i = 0; i < `SCHED_NUM_CHAN; i++)
			hit[i] = bus_wr.en && (bus_wr.chan == chan_idx_t'(i));
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			chan_value <= '0;
			chan_update <= '0;
		end else begin
			chan_update <= hit; // high while the new value shows
			for (int i = 0; i < `SCHED_NUM_CHAN; i++) begin
				if (hit[i])
					chan_value[i] <= bus_wr.data;
			end
		end
	end

endmodule

// ==== src/sched_top.sv ====
`timescale 1ns/10ps

`include "sched_settings.svh"

module sched_top (
	input  logic clk,
	input  logic rst,

	// timebase control
	input  logic start,
	input  logic stop,

	// host command port
	input  logic cmd_valid,
	output logic cmd_ready,
	input  sched_cmd_pkg::raw_cmd_t cmd,

	output logic [31:0] current_time,
	output logic [`SCHED_NUM_CHAN-1:0][31:0] chan_value,
	output logic [`SCHED_NUM_CHAN-1:0] chan_update,
	output logic [15:0] bad_cmd_count
);

	import sched_bus_pkg::*;
	import sched_cmd_pkg::*;

	logic running;

	// fifo to decode
	logic fifo_valid;
	logic fifo_ready;
	raw_cmd_t fifo_data;

	// decode to execute
	logic dec_valid;
	logic dec_ready;
	sched_cmd_t dec_cmd;

	bus_wr_t bus_wr;

	sched_timebase u_timebase (
		.clk(clk),
		.rst(rst),
		.start(start),
		.stop(stop),
		.running(running),
		.current_time(current_time)
	);

	cmd_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.in_valid(cmd_valid),
		.in_ready(cmd_ready),
		.in_data(cmd),
		.out_valid(fifo_valid),
		.out_ready(fifo_ready),
		.out_data(fifo_data)
	);

	sched_decode u_decode (
		.clk(clk),
		.rst(rst),
		.raw_valid(fifo_valid),
		.raw_ready(fifo_ready),
		.raw(fifo_data),
		.cmd_valid(dec_valid),
		.cmd_ready(dec_ready),
		.cmd(dec_cmd),
		.bad_cmd_count(bad_cmd_count)
	);

	sched_execute u_execute (
		.clk(clk),
		.rst(rst),
		.running(running),
		.current_time(current_time),
		.cmd_valid(dec_valid),
		.cmd_ready(dec_ready),
		.cmd(dec_cmd),
		.bus_wr(bus_wr)
	);

	channel_bank u_bank (
		.clk(clk),
		.rst(rst),
		.bus_wr(bus_wr),
		.chan_value(chan_value),
		.chan_update(chan_update)
	);

endmodule

// ==== bench/sched_tb.sv ====
`timescale 1ns/10ps

`include "sched_settings.svh"

module sched_tb;

	import sched_bus_pkg::*;
	import sched_cmd_pkg::*;

	localparam int NUM_ROWS = 29;
	localparam int PUSH_TIMEOUT = 50;     // cycles
	localparam int UPDATE_TIMEOUT = 200;  // cycles
	localparam int QUIET_CYCLES = 8;
	localparam int PAST_DUE_LATENCY = 4;  // push edge to chan_update

	// stimulus and expected result for one row
	typedef struct packed {
		logic [3:0] test;
		logic [31:0] tag;
		logic [15:0] addr;
		logic [31:0] data;
		logic bad;        // address outside the channel range
		chan_idx_t chan;  // expected channel when not bad
	} row_t;

	logic clk;
	logic rst;
	logic start;
	logic stop;
	logic cmd_valid;
	logic cmd_ready;
	raw_cmd_t cmd;
	logic [31:0] current_time;
	logic [`SCHED_NUM_CHAN-1:0][31:0] chan_value;
	logic [`SCHED_NUM_CHAN-1:0] chan_update;
	logic [15:0] bad_cmd_count;

	row_t rows [NUM_ROWS];
	logic [31:0] model [`SCHED_NUM_CHAN];  // expected channel registers
	logic [31:0] lfsr;
	int nrows;
	int errors;
	int tests_passed;
	int tests_failed;
	int bad_expected;

	sched_top u_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.stop(stop),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.current_time(current_time),
		.chan_value(chan_value),
		.chan_update(chan_update),
		.bad_cmd_count(bad_cmd_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// drive and sample point just after the rising edge
	task automatic tick();
		@(posedge clk);
		#5;
	endtask

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic rand_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w = {w[30:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic add_row(input int test, input logic [31:0] tag, input logic [15:0] addr,
		input logic [31:0] data, input bit rnd, input bit bad, input int chan);
		row_t r;
		r.test = 4'(test);
		r.tag = tag;
		r.addr = addr;
		r.data = data;
		if (rnd)
			rand_word(r.data);
		r.bad = bad;
		r.chan = chan_idx_t'(chan);
		rows[nrows] = r;
		nrows++;
	endtask

	task automatic load_table();
		nrows = 0;
		// timed execution with future tags
		add_row(1, 32'd20, 16'h0040, 32'h1111_a001, 0, 0, 0);
		add_row(1, 32'd35, 16'h0041, 32'h1111_a002, 0, 0, 1);
		add_row(1, 32'd50, 16'h0042, 32'h0, 1, 0, 2);
		add_row(1, 32'd70, 16'h0043, 32'h1111_a004, 0, 0, 3);
		// ordering with falling tags and two writes to channel 2
		add_row(2, 32'd60, 16'h0042, 32'h2222_b001, 0, 0, 2);
		add_row(2, 32'd45, 16'h0041, 32'h2222_b002, 0, 0, 1);
		add_row(2, 32'd30, 16'h0042, 32'h2222_b003, 0, 0, 2);
		add_row(2, 32'd15, 16'h0040, 32'h2222_b004, 0, 0, 0);
		add_row(2, 32'd5, 16'h0043, 32'h2222_b005, 0, 0, 3);
		// address decode
		add_row(3, 32'd10, 16'h003f, 32'hdead_0001, 0, 1, 0); // just below base
		add_row(3, 32'd10, 16'h0041, 32'h3333_c001, 0, 0, 1);
		add_row(3, 32'd10, 16'h0044, 32'hdead_0002, 0, 1, 0); // one past last
		add_row(3, 32'd10, 16'h0000, 32'hdead_0003, 0, 1, 0);
		add_row(3, 32'd10, 16'hffff, 32'hdead_0004, 0, 1, 0);
		add_row(3, 32'd10, 16'h0043, 32'h3333_c002, 0, 0, 3);
		add_row(3, 32'd10, 16'h0040, 32'h0, 1, 0, 0);
		// back-pressure with more rows than the pipeline holds
		for (int i = 0; i < 12; i++)
			add_row(4, 32'd0, `SCHED_CHAN_BASE + 16'(i % 4), 32'h0, 1, 0, i % 4);
		// past due once the timebase runs
		add_row(5, 32'd0, 16'h0041, 32'h0, 1, 0, 1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED at %0d ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic pulse_start();
		start = 1'b1;
		tick();
		start = 1'b0;
	endtask

	task automatic pulse_stop();
		stop = 1'b1;
		tick();
		stop = 1'b0;
	endtask

	// offer a row to the host port, taken at the next edge while cmd_ready is high
	task automatic push_row(input row_t r, input int patience, output bit accepted);
		int waited;
		waited = 0;
		accepted = 1'b0;
		cmd_valid = 1'b1;
		cmd.cmd_time = r.tag;
		cmd.data = r.data;
		cmd.addr = r.addr;
		while (!cmd_ready && waited < patience) begin
			tick();
			waited++;
		end
		if (cmd_ready) begin
			accepted = 1'b1;
			tick(); // accepted at this edge
		end
		cmd_valid = 1'b0;
		if (!accepted && patience > 0) begin
			$display("ERROR: cmd_ready stayed low for %0d cycles at %0d ns",
				patience, $time);
			errors++;
		end
	endtask

	task automatic wait_update(output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < UPDATE_TIMEOUT && !seen; n++) begin
			tick();
			seen = (chan_update != '0);
		end
		if (!seen) begin
			$display("ERROR: no channel update within %0d cycles at %0d ns",
				UPDATE_TIMEOUT, $time);
			errors++;
		end
	endtask

	// push one group with the timebase stopped, then start it and collect the writes
	task automatic run_group(input int test, input string name, input bit until_full);
		int pending [$];
		int err_before;
		int accepted;
		bit ok;
		bit seen;
		row_t r;
		logic [`SCHED_NUM_CHAN-1:0] onehot;
		err_before = errors;
		accepted = 0;
		pulse_stop();
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (rows[i].test == 4'(test)) begin
				push_row(rows[i], until_full ? 0 : PUSH_TIMEOUT, ok);
				if (!ok)
					break;
				accepted++;
				if (rows[i].bad)
					bad_expected++;
				else
					pending.push_back(i);
			end
		end
		if (until_full &&
			(accepted < `SCHED_FIFO_DEPTH || accepted > `SCHED_FIFO_DEPTH + 2)) begin
			$display("FAILED at %0d ns: accepted = %0d, expected %0d to %0d", $time,
				accepted, `SCHED_FIFO_DEPTH, `SCHED_FIFO_DEPTH + 2);
			errors++;
		end
		pulse_start();
		for (int k = 0; k < pending.size(); k++) begin
			r = rows[pending[k]];
			wait_update(seen);
			if (!seen)
				break;
			onehot = '0;
			onehot[r.chan] = 1'b1; // wrong channel means out of order
			if (chan_update !== onehot)
				report_mismatch("chan_update", 32'(chan_update), 32'(onehot));
			model[r.chan] = r.data;
			if (chan_value[r.chan] !== r.data)
				report_mismatch($sformatf("chan_value[%0d]", r.chan),
					chan_value[r.chan], r.data);
			if (test == 1 && current_time < r.tag + 32'd1) begin
				$display("FAILED at %0d ns: current_time = %0d, expected at least %0d",
					$time, current_time, r.tag + 32'd1);
				errors++;
			end
		end
		for (int q = 0; q < QUIET_CYCLES; q++) begin
			tick();
			if (chan_update != '0)
				report_mismatch("chan_update", 32'(chan_update), 32'd0);
		end
		if (bad_cmd_count !== 16'(bad_expected))
			report_mismatch("bad_cmd_count", 32'(bad_cmd_count), 32'(bad_expected));
		for (int c = 0; c < `SCHED_NUM_CHAN; c++) begin
			if (chan_value[c] !== model[c])
				report_mismatch($sformatf("chan_value[%0d]", c), chan_value[c], model[c]);
		end
		finish_test(name, err_before);
	endtask

	// timebase already running, so the tag is in the past
	task automatic past_due(input int test, input string name);
		int err_before;
		int cycles;
		bit ok;
		row_t r;
		err_before = errors;
		cycles = 0;
		r = rows[0];
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (rows[i].test == 4'(test))
				r = rows[i];
		end
		push_row(r, PUSH_TIMEOUT, ok);
		if (ok) begin
			while (chan_update == '0 && cycles < UPDATE_TIMEOUT) begin
				tick();
				cycles++;
			end
			if (chan_update == '0) begin
				$display("ERROR: past-due command never reached its channel");
				errors++;
			end else begin
				model[r.chan] = r.data;
				if (cycles != PAST_DUE_LATENCY)
					report_mismatch("push to chan_update cycles", cycles, PAST_DUE_LATENCY);
				if (chan_value[r.chan] !== r.data)
					report_mismatch($sformatf("chan_value[%0d]", r.chan),
						chan_value[r.chan], r.data);
			end
		end
		finish_test(name, err_before);
	endtask

	initial begin
		int err_before;
		rst = 1'b1;
		start = 1'b0;
		stop = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		bad_expected = 0;
		lfsr = 32'd87050;
		for (int c = 0; c < `SCHED_NUM_CHAN; c++)
			model[c] = '0;
		load_table();

		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
		tick();

		// outputs straight after reset
		err_before = errors;
		if (cmd_ready !== 1'b1)
			report_mismatch("cmd_ready", 32'(cmd_ready), 32'd1);
		if (chan_update !== '0)
			report_mismatch("chan_update", 32'(chan_update), 32'd0);
		for (int c = 0; c < `SCHED_NUM_CHAN; c++) begin
			if (chan_value[c] !== 32'd0)
				report_mismatch($sformatf("chan_value[%0d]", c), chan_value[c], 32'd0);
		end
		if (current_time !== 32'd0)
			report_mismatch("current_time", current_time, 32'd0);
		if (bad_cmd_count !== 16'd0)
			report_mismatch("bad_cmd_count", 32'(bad_cmd_count), 32'd0);
		finish_test("reset state", err_before);

		run_group(1, "timed execution", 1'b0);
		run_group(2, "ordering", 1'b0);
		run_group(3, "address decode", 1'b0);
		run_group(4, "back-pressure", 1'b1);
		past_due(5, "past-due command");

		$display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
src/sched_bus_pkg.sv
src/sched_cmd_pkg.sv
src/sched_timebase.sv
src/cmd_fifo.sv
src/sched_decode.sv
src/sched_execute.sv
src/channel_bank.sv
src/sched_top.sv
bench/sched_tb.sv
